/* src/scaler_pkg.sv */
// power-of-two box averaging only; means truncate, target width is limited to max_tar_width
package scaler_pkg;

    localparam int pix_w         = 8;
    localparam int max_tar_width = 256;
    localparam int tar_width_w   = 9;
    localparam int tar_height_w  = 10;
    localparam int max_x_log2    = 2;
    localparam int max_y_log2    = 2;
    localparam int sum_w         = pix_w + max_x_log2 + max_y_log2; // full 4x4 block of 255
    localparam int in_col_w      = 11;                               // up to 256 << 2 input pixels

    typedef struct packed {
        logic [pix_w-1:0] r;
        logic [pix_w-1:0] g;
        logic [pix_w-1:0] b;
    } rgb_t;

    typedef struct packed {
        logic [1:0]              x_log2;
        logic [1:0]              y_log2;
        logic [tar_width_w-1:0]  tar_width;
        logic [tar_height_w-1:0] tar_height;
    } scale_cfg_t;

    // guard to horizontal stage
    typedef struct packed {
        logic valid;
        rgb_t pixel;
        logic group_end;
        logic row_end;
    } guard_beat_t;

    // horizontal to vertical stage, one beat per finished group
    typedef struct packed {
        logic             valid;
        logic             row_end;
        logic [sum_w-1:0] r_sum;
        logic [sum_w-1:0] g_sum;
        logic [sum_w-1:0] b_sum;
    } hsum_t;

    // place of an input row inside its vertical group
    typedef enum logic [1:0] {
        row_first,
        row_mid,
        row_last,
        row_only
    } row_role_t;

endpackage

/* src/stream_guard.sv */
// config is sampled only on the vsync falling edge; a sync error holds the stream until reset
`timescale 1ns/10ps

module stream_guard (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 vsync,
    input  logic                                 hsync,
    input  logic                                 data_enable,
    input  scaler_pkg::rgb_t                     pix_in,
    input  logic [1:0]                           x_factor_log2,
    input  logic [1:0]                           y_factor_log2,
    input  logic [scaler_pkg::tar_width_w-1:0]   tar_width,
    input  logic [scaler_pkg::tar_height_w-1:0]  tar_height,
    output scaler_pkg::scale_cfg_t               cfg,
    output logic                                 frame_start,
    output scaler_pkg::guard_beat_t              beat
);

    import scaler_pkg::*;

    logic                  vsync_d;
    logic                  vsync_fall;
    logic                  cfg_ok;
    logic                  cfg_valid;
    logic                  sync_err;
    logic [in_col_w-1:0]   in_col;
    logic [in_col_w-1:0]   last_col;
    logic [max_x_log2-1:0] grp_mask;

    assign vsync_fall = vsync_d && !vsync;

    // x must decimate, y may pass rows through
    assign cfg_ok = (x_factor_log2 != 2'd0) && (x_factor_log2 <= max_x_log2) &&
                    (y_factor_log2 <= max_y_log2) &&
                    (tar_width != '0) && (tar_width <= max_tar_width) &&
                    (tar_height != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vsync_d     <= 1'b0;
            frame_start <= 1'b0;
            cfg_valid   <= 1'b0;
            cfg         <= '0;
        end else begin
            vsync_d     <= vsync;
            frame_start <= vsync_fall;
            if (vsync_fall) begin
                cfg_valid <= cfg_ok;
                cfg       <= '{x_log2: x_factor_log2, y_log2: y_factor_log2,
                               tar_width: tar_width, tar_height: tar_height};
            end
        end
    end

    assign last_col = (in_col_w'(cfg.tar_width) << cfg.x_log2) - in_col_w'(1);
    assign grp_mask = max_x_log2'((1 << cfg.x_log2) - 1);

    always_comb begin
        beat.valid     = data_enable && cfg_valid && !sync_err;
        beat.pixel     = pix_in;
        beat.group_end = (in_col[max_x_log2-1:0] & grp_mask) == grp_mask;
        beat.row_end   = in_col == last_col;
    end

    // accepted pixels in the current input row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_col <= '0;
        end else if (vsync_fall) begin
            in_col <= '0;
        end else if (beat.valid) begin
            in_col <= beat.row_end ? '0 : in_col + in_col_w'(1);
        end
    end

    // hsync inside a row means pixels were lost
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_err <= 1'b0;
        end else if (hsync && in_col != '0) begin
            sync_err <= 1'b1; // sticky
        end
    end

endmodule

/* src/h_decimator.sv */
// group boundaries come from the guard; sums are raw, normalising happens in the vertical stage
`timescale 1ns/10ps

module h_decimator (
    input  logic                    clk,
    input  logic                    rst_n,
    input  scaler_pkg::scale_cfg_t  cfg,
    input  scaler_pkg::guard_beat_t beat,
    output scaler_pkg::hsum_t       hsum
);

    import scaler_pkg::*;

    logic [max_x_log2-1:0] pos;
    logic [max_x_log2-1:0] grp_last;
    logic                  first;
    logic                  out_vld;
    logic                  out_row_end;
    logic [sum_w-1:0]      acc_r, acc_g, acc_b;
    logic [sum_w-1:0]      nxt_r, nxt_g, nxt_b;
    logic [sum_w-1:0]      out_r, out_g, out_b;

    function automatic logic [sum_w-1:0] add_px(input logic             restart,
                                                input logic [sum_w-1:0] acc,
                                                input logic [pix_w-1:0] px);
        return (restart ? '0 : acc) + sum_w'(px);
    endfunction

    assign grp_last = max_x_log2'((1 << cfg.x_log2) - 1);
    assign first    = pos == '0;

    assign nxt_r = add_px(first, acc_r, beat.pixel.r);
    assign nxt_g = add_px(first, acc_g, beat.pixel.g);
    assign nxt_b = add_px(first, acc_b, beat.pixel.b);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos     <= '0;
            out_vld <= 1'b0;
        end else begin
            out_vld <= beat.valid && beat.group_end;
            if (beat.valid) begin
                pos <= (beat.group_end || pos == grp_last) ? '0 : pos + 1'b1; // realign on end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat.valid) begin
            acc_r <= nxt_r;
            acc_g <= nxt_g;
            acc_b <= nxt_b;
        end
        if (beat.valid && beat.group_end) begin
            out_r       <= nxt_r;
            out_g       <= nxt_g;
            out_b       <= nxt_b;
            out_row_end <= beat.row_end;
        end
    end

    assign hsum = '{valid: out_vld, row_end: out_row_end,
                    r_sum: out_r, g_sum: out_g, b_sum: out_b};

endmodule

/* src/v_decimator.sv */
// row store holds one partial sum per output column; needs complete rows of tar_width groups
`timescale 1ns/10ps

module v_decimator (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   frame_start,
    input  scaler_pkg::scale_cfg_t cfg,
    input  scaler_pkg::hsum_t      hsum,
    output logic                   en_output,
    output logic                   frame_done,
    output scaler_pkg::rgb_t       pix_out
);

    import scaler_pkg::*;

    logic [tar_width_w-1:0]              st_col;
    logic [$clog2(max_tar_width)-1:0]    st_idx;
    logic [max_y_log2-1:0]               row_idx;
    logic [max_y_log2-1:0]               last_row_idx;
    row_role_t                           role;
    logic                                use_store;
    logic                                do_write;
    logic                                do_out;
    logic [2:0]                          sh;
    logic [sum_w-1:0]                    r_mem [max_tar_width];
    logic [sum_w-1:0]                    g_mem [max_tar_width];
    logic [sum_w-1:0]                    b_mem [max_tar_width];
    logic [sum_w-1:0]                    tot_r, tot_g, tot_b;
    logic [tar_width_w-1:0]              out_px;
    logic [tar_height_w-1:0]             out_row;
    logic                                px_wrap;
    logic                                row_wrap;

    function automatic logic [sum_w-1:0] col_sum(input logic             add_stored,
                                                 input logic [sum_w-1:0] stored,
                                                 input logic [sum_w-1:0] part);
        return add_stored ? stored + part : part;
    endfunction

    assign st_idx       = st_col[$clog2(max_tar_width)-1:0];
    assign last_row_idx = max_y_log2'((1 << cfg.y_log2) - 1);

    always_comb begin
        if (cfg.y_log2 == 2'd0) begin
            role = row_only;
        end else if (row_idx == '0) begin
            role = row_first;
        end else if (row_idx == last_row_idx) begin
            role = row_last;
        end else begin
            role = row_mid;
        end
    end

    assign use_store = (role == row_mid) || (role == row_last);
    assign do_write  = hsum.valid && ((role == row_first) || (role == row_mid));
    assign do_out    = hsum.valid && ((role == row_last) || (role == row_only));
    assign sh        = 3'(cfg.x_log2) + 3'(cfg.y_log2); // divide by block area

    assign tot_r = col_sum(use_store, r_mem[st_idx], hsum.r_sum);
    assign tot_g = col_sum(use_store, g_mem[st_idx], hsum.g_sum);
    assign tot_b = col_sum(use_store, b_mem[st_idx], hsum.b_sum);

    // column and row-in-group position of incoming sums
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_col  <= '0;
            row_idx <= '0;
        end else if (frame_start) begin
            st_col  <= '0;
            row_idx <= '0;
        end else if (hsum.valid) begin
            st_col <= hsum.row_end ? '0 : st_col + 1'b1;
            if (hsum.row_end) begin
                row_idx <= (row_idx == last_row_idx) ? '0 : row_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            r_mem[st_idx] <= tot_r;
            g_mem[st_idx] <= tot_g;
            b_mem[st_idx] <= tot_b;
        end
        if (do_out) begin
            pix_out.r <= pix_w'(tot_r >> sh);
            pix_out.g <= pix_w'(tot_g >> sh);
            pix_out.b <= pix_w'(tot_b >> sh);
        end
    end

    assign px_wrap  = out_px == cfg.tar_width - tar_width_w'(1);
    assign row_wrap = out_row == cfg.tar_height - tar_height_w'(1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_output  <= 1'b0;
            frame_done <= 1'b0;
            out_px     <= '0;
            out_row    <= '0;
        end else begin
            en_output  <= do_out;
            frame_done <= en_output && px_wrap && row_wrap;
            if (frame_start) begin
                out_px  <= '0;
                out_row <= '0;
            end else if (en_output) begin
                out_px <= px_wrap ? '0 : out_px + 1'b1;
                if (px_wrap) begin
                    out_row <= row_wrap ? '0 : out_row + 1'b1;
                end
            end
        end
    end

endmodule

/* src/downsample_scaler.sv */
// no back-pressure; en_output trails the last input pixel of each block by two cycles
`timescale 1ns/10ps

module downsample_scaler (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 vsync,
    input  logic                                 hsync,
    input  logic                                 data_enable,
    input  scaler_pkg::rgb_t                     pix_in,
    input  logic [1:0]                           x_factor_log2,
    input  logic [1:0]                           y_factor_log2,
    input  logic [scaler_pkg::tar_width_w-1:0]   tar_width,
    input  logic [scaler_pkg::tar_height_w-1:0]  tar_height,
    output logic                                 en_output,
    output scaler_pkg::rgb_t                     pix_out,
    output logic                                 frame_done
);

    import scaler_pkg::*;

    scale_cfg_t  cfg;
    logic        frame_start;
    guard_beat_t beat;
    hsum_t       hsum;

    stream_guard u_guard (
        .clk           (clk),
        .rst_n         (rst_n),
        .vsync         (vsync),
        .hsync         (hsync),
        .data_enable   (data_enable),
        .pix_in        (pix_in),
        .x_factor_log2 (x_factor_log2),
        .y_factor_log2 (y_factor_log2),
        .tar_width     (tar_width),
        .tar_height    (tar_height),
        .cfg           (cfg),
        .frame_start   (frame_start),
        .beat          (beat)
    );

    h_decimator u_hdec (
        .clk   (clk),
        .rst_n (rst_n),
        .cfg   (cfg),
        .beat  (beat),
        .hsum  (hsum)
    );

    v_decimator u_vdec (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .cfg         (cfg),
        .hsum        (hsum),
        .en_output   (en_output),
        .frame_done  (frame_done),
        .pix_out     (pix_out)
    );

endmodule

/* dv/scaler_chk.sv */
// passive output checks; pix_out is only required to be known while en_output is high
`timescale 1ns/10ps

module scaler_chk (
    input logic             clk,
    input logic             rst_n,
    input logic             en_output,
    input logic             frame_done,
    input scaler_pkg::rgb_t pix_out
);

    outputs_low_in_reset: assert property (@(posedge clk) !rst_n |-> !en_output && !frame_done)
        else $error("en_output or frame_done high while in reset");

    single_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        frame_done |=> !frame_done)
        else $error("frame_done high on two consecutive cycles");

    known_pixel: assert property (@(posedge clk) disable iff (!rst_n)
        en_output |-> !$isunknown(pix_out))
        else $error("pix_out has unknown bits while en_output is high");

endmodule

bind downsample_scaler scaler_chk u_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .en_output  (en_output),
    .frame_done (frame_done),
    .pix_out    (pix_out)
);

/* dv/tb_downsample_scaler.sv */
// random frames from a fixed LCG seed; frame sizes are kept small so the run stays short
`timescale 1ns/10ps

module tb_downsample_scaler;

    import scaler_pkg::*;

    localparam int max_frame_px    = (12 << 2) * (3 << 2); // largest random frame
    localparam int max_pixels      = 512 + 10 * max_frame_px + 24 + 600 + 96;
    localparam int watchdog_cycles = max_pixels * 4 + 2000;

    logic                    clk;
    logic                    rst_n;
    logic                    vsync;
    logic                    hsync;
    logic                    data_enable;
    rgb_t                    pix_in;
    logic [1:0]              x_factor_log2;
    logic [1:0]              y_factor_log2;
    logic [tar_width_w-1:0]  tar_width;
    logic [tar_height_w-1:0] tar_height;
    logic                    en_output;
    rgb_t                    pix_out;
    logic                    frame_done;

    logic [31:0] lcg_state = 32'ha9617b23;
    int          cyc = 0;
    int          err_count = 0;
    int          out_count = 0;
    int          done_count = 0;
    int          exp_done = 0;
    int          err_base, out_base, done_base, exp_done_base;
    int          tests_pass = 0;
    int          tests_fail = 0;
    bit          stream_err;
    logic [23:0] exp_pix[$];
    int          exp_cyc[$];
    int          exp_done_cyc[$];
    int          acc_r[max_tar_width];
    int          acc_g[max_tar_width];
    int          acc_b[max_tar_width];
    logic [23:0] mon_pix;
    int          mon_cyc;
    int          mon_done_cyc;

    downsample_scaler u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .vsync         (vsync),
        .hsync         (hsync),
        .data_enable   (data_enable),
        .pix_in        (pix_in),
        .x_factor_log2 (x_factor_log2),
        .y_factor_log2 (y_factor_log2),
        .tar_width     (tar_width),
        .tar_height    (tar_height),
        .en_output     (en_output),
        .pix_out       (pix_out),
        .frame_done    (frame_done)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk; // 4 ns period

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_range(input int n);
        return int'((rand_next() >> 8) % 32'(n)); // low LCG bits are weak
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #0.5;
        data_enable = 1'b0;
        hsync       = 1'b0;
    endtask

    task automatic do_reset();
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #0.5;
        rst_n      = 1'b1;
        stream_err = 1'b0;
    endtask

    task automatic drain();
        while (exp_pix.size() != 0) begin
            @(posedge clk);
        end
        repeat (6) @(posedge clk);
        #0.5;
    endtask

    task automatic start_test();
        err_base      = err_count;
        out_base      = out_count;
        done_base     = done_count;
        exp_done_base = exp_done;
    endtask

    task automatic finish_test(input int num, input string name);
        drain();
        check_value("frame_done count", 32'(done_count - done_base),
                    32'(exp_done - exp_done_base));
        if (err_count == err_base) begin
            tests_pass++;
            $display("test %0d %s: pass", num, name);
        end else begin
            tests_fail++;
            $display("test %0d %s: FAIL with %0d errors", num, name, err_count - err_base);
        end
    endtask

    // one frame; the model keeps a running box sum per output column
    task automatic run_frame(input int x, input int y, input int w, input int h,
                             input bit gaps, input int err_pos);
        int          rows;
        int          cols;
        int          idx;
        int          oc;
        logic [31:0] word;
        logic [31:0] er, eg, eb;
        bit          cfg_ok;
        cfg_ok = x >= 1 && x <= 2 && y <= 2 && w >= 1 && w <= max_tar_width && h >= 1;
        rows   = h << y;
        cols   = w << x;
        idx    = 0;
        next_cycle();
        x_factor_log2 = 2'(x);
        y_factor_log2 = 2'(y);
        tar_width     = tar_width_w'(w);
        tar_height    = tar_height_w'(h);
        vsync         = 1'b1;
        repeat (2) next_cycle();
        vsync = 1'b0;
        repeat (2) next_cycle();
        for (int r = 0; r < rows; r++) begin
            next_cycle();
            hsync = 1'b1; // line sync between rows
            for (int c = 0; c < cols; c++) begin
                if (gaps) begin
                    repeat (rand_range(3)) next_cycle();
                end
                if (idx == err_pos) begin
                    next_cycle();
                    hsync      = 1'b1; // lands inside the row
                    stream_err = 1'b1;
                end
                next_cycle();
                word        = rand_next();
                data_enable = 1'b1;
                pix_in      = word[31:8];
                idx++;
                if (cfg_ok && !stream_err) begin
                    oc = c >> x;
                    if (r % (1 << y) == 0 && c % (1 << x) == 0) begin
                        acc_r[oc] = 0;
                        acc_g[oc] = 0;
                        acc_b[oc] = 0;
                    end
                    acc_r[oc] += int'(word[31:24]);
                    acc_g[oc] += int'(word[23:16]);
                    acc_b[oc] += int'(word[15:8]);
                    if (r % (1 << y) == (1 << y) - 1 && c % (1 << x) == (1 << x) - 1) begin
                        er = acc_r[oc] >> (x + y);
                        eg = acc_g[oc] >> (x + y);
                        eb = acc_b[oc] >> (x + y);
                        exp_pix.push_back({er[7:0], eg[7:0], eb[7:0]});
                        exp_cyc.push_back(cyc + 2); // two register stages
                    end
                    if (r == rows - 1 && c == cols - 1) begin
                        exp_done_cyc.push_back(cyc + 3); // one after the last output
                    end
                end
            end
        end
        next_cycle();
        if (cfg_ok && !stream_err) begin
            exp_done++;
        end
    endtask

    // sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (en_output) begin
                out_count++;
                if (exp_pix.size() == 0) begin
                    $display("en_output high at cycle %0d with no output expected", cyc);
                    err_count++;
                end else begin
                    mon_pix = exp_pix.pop_front();
                    mon_cyc = exp_cyc.pop_front();
                    check_value("pix_out", pix_out, mon_pix);
                    check_value("en_output cycle", 32'(cyc), 32'(mon_cyc));
                end
            end
            if (frame_done) begin
                done_count++;
                if (exp_done_cyc.size() == 0) begin
                    $display("frame_done high at cycle %0d with no frame end expected", cyc);
                    err_count++;
                end else begin
                    mon_done_cyc = exp_done_cyc.pop_front();
                    check_value("frame_done cycle", 32'(cyc), 32'(mon_done_cyc));
                end
            end
        end
    end

    initial begin
        #(watchdog_cycles * 4);
        $display("timeout: the run did not end within %0d cycles", watchdog_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int w;
        int h;
        rst_n         = 1'b0;
        vsync         = 1'b0;
        hsync         = 1'b0;
        data_enable   = 1'b0;
        pix_in        = '0;
        x_factor_log2 = '0;
        y_factor_log2 = '0;
        tar_width     = '0;
        tar_height    = '0;
        stream_err    = 1'b0;
        do_reset();

        start_test();
        repeat (40) next_cycle();
        check_value("output count", 32'(out_count - out_base), 32'd0);
        finish_test(1, "idle after reset");

        start_test();
        w = 1 + rand_range(64);
        h = 1 + rand_range(4);
        run_frame(1, 0, w, h, 1'b0, -1);
        drain();
        check_value("output count", 32'(out_count - out_base), 32'(w * h));
        finish_test(2, "horizontal halving");

        start_test();
        for (int x = 1; x <= 2; x++) begin
            for (int y = 0; y <= 2; y++) begin
                w = 1 + rand_range(12);
                h = 1 + rand_range(3);
                run_frame(x, y, w, h, 1'b1, -1);
            end
        end
        finish_test(3, "all factor pairs");

        start_test();
        run_frame(0, 1, 1 + rand_range(12), 2, 1'b0, -1);
        run_frame(1, 0, 300, 1, 1'b0, -1); // wider than the row store
        run_frame(2, 2, 1 + rand_range(12), 1 + rand_range(3), 1'b1, -1);
        finish_test(4, "invalid config");

        start_test();
        w = 2 + rand_range(11);
        run_frame(1, 0, w, 2, 1'b0, (w << 1) + 3);
        run_frame(1, 1, w, 1, 1'b1, -1); // still frozen
        drain();
        do_reset();
        run_frame(1, 1, w, 2, 1'b1, -1);
        finish_test(5, "mid-row hsync");

        start_test();
        w = 1 + rand_range(12);
        h = 1 + rand_range(3);
        run_frame(2, 1, w, h, 1'b1, -1);
        w = 1 + rand_range(12);
        h = 1 + rand_range(3);
        run_frame(1, 2, w, h, 1'b0, -1);
        finish_test(6, "back-to-back frames");

        $display("summary: %0d tests passed, %0d failed, %0d errors",
                 tests_pass, tests_fail, err_count);
        if (tests_fail == 0 && err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
src/scaler_pkg.sv
src/stream_guard.sv
src/h_decimator.sv
src/v_decimator.sv
src/downsample_scaler.sv
dv/scaler_chk.sv
dv/tb_downsample_scaler.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f \
    --top-module tb_downsample_scaler \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
echo "simulation finished without failures"
